//--- fir_regmap_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR register map definitions
// widths, tap count, register addresses
// and control bit positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fir_regmap_pkg;

    // datapath and bus widths
    localparam int data_w  = 32;
    localparam int addr_w  = 12;

    // filter length, index wide enough for 0..10
    localparam int tap_num = 11;
    localparam int idx_w   = 4;

    // register addresses, taps are 4 bytes apart
    localparam logic [addr_w-1:0] addr_ctrl     = 12'h000;
    localparam logic [addr_w-1:0] addr_tap_base = 12'h020;

    // bits of the control register
    localparam int bit_start = 0;
    localparam int bit_done  = 1;
    localparam int bit_idle  = 2;

endpackage

`default_nettype wire

//--- fir_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR control state encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fir_ctrl_pkg;

    // filter run sequencing
    typedef enum logic [1:0] {
        run_idle,
        run_accept,
        run_mac,
        run_wait_out
    } run_state_e;

    // register port read channel
    typedef enum logic {
        lite_idle,
        lite_read_resp
    } lite_state_e;

endpackage

`default_nettype wire

//--- fir_sample_ring.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR sample history ring
// last eleven samples, read by age
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fir_sample_ring (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  logic                              clear,
    input  logic                              push,
    input  logic [fir_regmap_pkg::data_w-1:0] push_data,
    input  logic [fir_regmap_pkg::idx_w-1:0]  age,
    output logic [fir_regmap_pkg::data_w-1:0] age_data
);
    import fir_regmap_pkg::*;

    logic [data_w-1:0] hist [tap_num];
    logic [idx_w-1:0]  wr_ptr;
    logic [idx_w:0]    rd_sum;
    logic [idx_w-1:0]  rd_ptr;

    // newest entry sits one below wr_ptr, step back by age and wrap
    assign rd_sum   = {1'b0, wr_ptr} + (idx_w+1)'(tap_num - 1) - {1'b0, age};
    assign rd_ptr   = (rd_sum >= tap_num) ? rd_sum[idx_w-1:0] - idx_w'(tap_num)
                                          : rd_sum[idx_w-1:0];
    assign age_data = hist[rd_ptr];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
            for (int i = 0; i < tap_num; i++) begin
                hist[i] <= '0;
            end
        end else if (clear) begin
            // a new run sees zero history
            wr_ptr <= '0;
            for (int i = 0; i < tap_num; i++) begin
                hist[i] <= '0;
            end
        end else if (push) begin
            hist[wr_ptr] <= push_data;
            wr_ptr       <= (wr_ptr == idx_w'(tap_num - 1)) ? '0 : wr_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- fir_reg_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR register decode
// lite-style register port, tap register
// file and ap_start/ap_done/ap_idle bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fir_reg_decode (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  logic                              awvalid,
    input  logic [fir_regmap_pkg::addr_w-1:0] awaddr,
    input  logic                              wvalid,
    input  logic [fir_regmap_pkg::data_w-1:0] wdata,
    input  logic                              arvalid,
    input  logic [fir_regmap_pkg::addr_w-1:0] araddr,
    input  logic                              rready,
    output logic                              awready,
    output logic                              wready,
    output logic                              arready,
    output logic                              rvalid,
    output logic [fir_regmap_pkg::data_w-1:0] rdata,
    input  logic [fir_regmap_pkg::idx_w-1:0]  tap_idx,
    input  logic                              run_busy,
    input  logic                              run_end,
    output logic [fir_regmap_pkg::data_w-1:0] tap_coef,
    output logic                              run_start
);
    import fir_regmap_pkg::*;
    import fir_ctrl_pkg::*;

    lite_state_e       lite_state;
    logic [addr_w-1:0] rd_addr;
    logic [data_w-1:0] rd_mux;
    logic [data_w-1:0] taps [tap_num];
    logic              ap_start;
    logic              ap_done;
    logic              ap_idle;
    logic              wr_acc;
    logic              rd_acc;
    logic              rd_done;
    logic              ctrl_wr;
    logic              tap_wr;

    // word aligned and inside the 11-entry tap window
    function automatic logic tap_hit(input logic [addr_w-1:0] addr);
        logic [addr_w-1:0] off;
        off = addr - addr_tap_base;
        return (addr >= addr_tap_base) && (off[1:0] == 2'b00) && (off[addr_w-1:2] < tap_num);
    endfunction

    function automatic logic [idx_w-1:0] tap_sel(input logic [addr_w-1:0] addr);
        logic [addr_w-1:0] off;
        off = addr - addr_tap_base;
        return off[idx_w+1:2];
    endfunction

    // write takes address and data in the same cycle
    assign wr_acc  = (lite_state == lite_idle) && awvalid && wvalid;
    assign rd_acc  = (lite_state == lite_idle) && arvalid && !wr_acc;
    assign rd_done = (lite_state == lite_read_resp) && rready;

    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign arready = rd_acc;
    assign rvalid  = (lite_state == lite_read_resp);

    assign ctrl_wr = wr_acc && (awaddr == addr_ctrl);
    // taps frozen while a run is going
    assign tap_wr  = wr_acc && ap_idle && tap_hit(awaddr);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            lite_state <= lite_idle;
        end else begin
            case (lite_state)
                lite_idle: begin
                    if (rd_acc) begin
                        lite_state <= lite_read_resp;
                    end
                end
                lite_read_resp: begin
                    if (rready) begin
                        lite_state <= lite_idle;
                    end
                end
                default: lite_state <= lite_idle;
            endcase
        end
    end

    always_comb begin
        rd_mux = '0;
        if (araddr == addr_ctrl) begin
            rd_mux[bit_start] = ap_start;
            rd_mux[bit_done]  = ap_done;
            rd_mux[bit_idle]  = ap_idle;
        end else if (tap_hit(araddr)) begin
            rd_mux = taps[tap_sel(araddr)];
        end
    end

    // read data sampled at accept, held until rready
    always_ff @(posedge axis_clk) begin
        if (rd_acc) begin
            rd_addr <= araddr;
            rdata   <= rd_mux;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (tap_wr) begin
            taps[tap_sel(awaddr)] <= wdata;
        end
    end

    assign tap_coef = (tap_idx < tap_num) ? taps[tap_idx] : '0;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            run_start <= 1'b0;
            ap_start  <= 1'b0;
            ap_done   <= 1'b0;
            ap_idle   <= 1'b1;
        end else begin
            run_start <= 1'b0;
            if (ctrl_wr && wdata[bit_start] && ap_idle) begin
                run_start <= 1'b1;
                ap_start  <= 1'b1;
                ap_idle   <= 1'b0;
                ap_done   <= 1'b0;
            end else if (run_busy) begin
                ap_start <= 1'b0;
            end
            // done only clears once the host has actually seen it
            if (run_end) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end else if (rd_done && (rd_addr == addr_ctrl) && rdata[bit_done]) begin
                ap_done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- fir_mac_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR multiply-accumulate engine
// input stream, run FSM and one shared
// multiplier and adder over 11 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fir_mac_execute (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  logic                              run_start,
    output logic                              run_busy,
    input  logic                              ss_tvalid,
    input  logic [fir_regmap_pkg::data_w-1:0] ss_tdata,
    input  logic                              ss_tlast,
    output logic                              ss_tready,
    output logic [fir_regmap_pkg::idx_w-1:0]  tap_idx,
    input  logic [fir_regmap_pkg::data_w-1:0] tap_coef,
    input  logic                              out_full,
    output logic                              mac_valid,
    output logic [fir_regmap_pkg::data_w-1:0] mac_data,
    output logic                              mac_last
);
    import fir_regmap_pkg::*;
    import fir_ctrl_pkg::*;

    run_state_e               state;
    logic [idx_w-1:0]         cnt;
    logic                     last_q;
    logic [data_w-1:0]        age_data;
    logic signed [data_w-1:0] acc;
    logic signed [data_w-1:0] product;
    logic signed [data_w-1:0] sum;
    logic                     in_xfer;
    logic                     mac_end;

    // no new sample while the previous result is still unsent
    assign ss_tready = (state == run_accept) && !out_full;
    assign in_xfer   = ss_tvalid && ss_tready;
    assign run_busy  = (state != run_idle);
    assign mac_end   = (state == run_mac) && (cnt == idx_w'(tap_num - 1));

    // tap k pairs with the sample k pushes old
    assign tap_idx = cnt;

    fir_sample_ring i_ring (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .clear      (run_start),
        .push       (in_xfer),
        .push_data  (ss_tdata),
        .age        (cnt),
        .age_data   (age_data)
    );

    // the one multiplier and the one adder, 32-bit wrap
    assign product = $signed(tap_coef) * $signed(age_data);
    assign sum     = acc + product;

    assign mac_valid = mac_end;
    assign mac_data  = sum;
    assign mac_last  = last_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state  <= run_idle;
            cnt    <= '0;
            last_q <= 1'b0;
        end else begin
            case (state)
                run_idle: begin
                    if (run_start) begin
                        state <= run_accept;
                    end
                end
                run_accept: begin
                    if (out_full) begin
                        state <= run_wait_out;
                    end else if (in_xfer) begin
                        state  <= run_mac;
                        cnt    <= '0;
                        last_q <= ss_tlast;
                    end
                end
                run_mac: begin
                    if (mac_end) begin
                        cnt   <= '0;
                        state <= last_q ? run_idle : run_accept;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                run_wait_out: begin
                    if (!out_full) begin
                        state <= run_accept;
                    end
                end
                default: state <= run_idle;
            endcase
        end
    end

    // partial sum, restarts with every sample
    always_ff @(posedge axis_clk) begin
        if (in_xfer) begin
            acc <= '0;
        end else if (state == run_mac) begin
            acc <= sum;
        end
    end

endmodule

`default_nettype wire

//--- fir_result_out.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR result stream output
// one-entry holding register with tlast
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fir_result_out (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  logic                              mac_valid,
    input  logic [fir_regmap_pkg::data_w-1:0] mac_data,
    input  logic                              mac_last,
    input  logic                              sm_tready,
    output logic                              sm_tvalid,
    output logic [fir_regmap_pkg::data_w-1:0] sm_tdata,
    output logic                              sm_tlast,
    output logic                              out_full,
    output logic                              run_end
);
    import fir_regmap_pkg::*;

    logic              full_q;
    logic [data_w-1:0] data_q;
    logic              last_q;

    assign sm_tvalid = full_q;
    assign sm_tdata  = data_q;
    assign sm_tlast  = last_q;
    assign out_full  = full_q;

    // end of run is the accepted beat carrying tlast
    assign run_end = full_q && sm_tready && last_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            full_q <= 1'b0;
        end else if (mac_valid) begin
            full_q <= 1'b1;
        end else if (sm_tready) begin
            full_q <= 1'b0;
        end
    end

    // payload only moves on load, stable while waiting for sm_tready
    always_ff @(posedge axis_clk) begin
        if (mac_valid) begin
            data_q <= mac_data;
            last_q <= mac_last;
        end
    end

endmodule

`default_nettype wire

//--- fir_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR filter top level
// register decode, MAC engine and result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fir_top (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  logic                              awvalid,
    input  logic [fir_regmap_pkg::addr_w-1:0] awaddr,
    input  logic                              wvalid,
    input  logic [fir_regmap_pkg::data_w-1:0] wdata,
    output logic                              awready,
    output logic                              wready,
    input  logic                              arvalid,
    input  logic [fir_regmap_pkg::addr_w-1:0] araddr,
    input  logic                              rready,
    output logic                              arready,
    output logic                              rvalid,
    output logic [fir_regmap_pkg::data_w-1:0] rdata,
    input  logic                              ss_tvalid,
    input  logic [fir_regmap_pkg::data_w-1:0] ss_tdata,
    input  logic                              ss_tlast,
    output logic                              ss_tready,
    input  logic                              sm_tready,
    output logic                              sm_tvalid,
    output logic [fir_regmap_pkg::data_w-1:0] sm_tdata,
    output logic                              sm_tlast
);
    import fir_regmap_pkg::*;

    logic [idx_w-1:0]  tap_idx;
    logic [data_w-1:0] tap_coef;
    logic              run_start;
    logic              run_busy;
    logic              run_end;
    logic              out_full;
    logic              mac_valid;
    logic [data_w-1:0] mac_data;
    logic              mac_last;

    fir_reg_decode i_decode (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .awready    (awready),
        .wready     (wready),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .tap_idx    (tap_idx),
        .run_busy   (run_busy),
        .run_end    (run_end),
        .tap_coef   (tap_coef),
        .run_start  (run_start)
    );

    fir_mac_execute i_execute (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .run_start  (run_start),
        .run_busy   (run_busy),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .tap_idx    (tap_idx),
        .tap_coef   (tap_coef),
        .out_full   (out_full),
        .mac_valid  (mac_valid),
        .mac_data   (mac_data),
        .mac_last   (mac_last)
    );

    fir_result_out i_result (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .mac_valid  (mac_valid),
        .mac_data   (mac_data),
        .mac_last   (mac_last),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .out_full   (out_full),
        .run_end    (run_end)
    );

endmodule

`default_nettype wire

//--- fir_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR handshake checker
// hold rules on the result stream and the
// register read channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fir_checker (
    input logic                              axis_clk,
    input logic                              axis_rst_n,
    input logic                              rvalid,
    input logic                              rready,
    input logic [fir_regmap_pkg::data_w-1:0] rdata,
    input logic                              ss_tready,
    input logic                              sm_tvalid,
    input logic                              sm_tready,
    input logic [fir_regmap_pkg::data_w-1:0] sm_tdata,
    input logic                              sm_tlast
);

    // stalled result keeps its payload
    sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
        else $error("sm_tvalid or its payload changed before sm_tready");

    // read response stays put until taken
    rd_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    // output back-pressure must stall the input
    in_stall: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready && $past(sm_tvalid && !sm_tready)) |-> !ss_tready)
        else $error("ss_tready high while the result stream is stalled");

endmodule

bind fir_top fir_checker i_checker (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast)
);

`default_nettype wire

//--- fir_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR filter testbench
// register access, two filter runs and
// comparison against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fir_tb;
    import fir_regmap_pkg::*;

    localparam int n_samples  = 40;
    localparam int wait_limit = 200;
    localparam int run_limit  = 4000;
    localparam int latency    = 12;

    logic              axis_clk;
    logic              axis_rst_n;
    logic              awvalid;
    logic [addr_w-1:0] awaddr;
    logic              wvalid;
    logic [data_w-1:0] wdata;
    logic              awready;
    logic              wready;
    logic              arvalid;
    logic [addr_w-1:0] araddr;
    logic              rready;
    logic              arready;
    logic              rvalid;
    logic [data_w-1:0] rdata;
    logic              ss_tvalid;
    logic [data_w-1:0] ss_tdata;
    logic              ss_tlast;
    logic              ss_tready;
    logic              sm_tready;
    logic              sm_tvalid;
    logic [data_w-1:0] sm_tdata;
    logic              sm_tlast;

    logic [data_w-1:0] taps_model [tap_num];
    logic [data_w-1:0] x_model [$];
    logic [data_w:0]   exp_q [$];
    int unsigned       in_stamp [$];
    int unsigned       cyc;
    logic [31:0]       lfsr_main;
    logic [31:0]       lfsr_rdy;
    logic              rdy_random;
    logic              tvalid_d;
    int                errors;
    int                timeouts;
    int                out_count;

    fir_top i_fir_top (.*);

    always #4 axis_clk = ~axis_clk;

    always @(posedge axis_clk) begin
        cyc <= cyc + 1;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_main = lfsr_step(lfsr_main);
            val = {val[30:0], lfsr_main[0]};
        end
        return val;
    endfunction

    // y[n] = sum of h[k] * x[n-k], samples before the start are zero
    function automatic logic [data_w-1:0] fir_ref(input int n);
        longint acc;
        acc = 0;
        for (int k = 0; k < tap_num; k++) begin
            if (n - k >= 0) begin
                acc += longint'($signed(taps_model[k])) * longint'($signed(x_model[n - k]));
            end
        end
        return acc[data_w-1:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic lite_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        int n;
        n = 0;
        @(posedge axis_clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        @(negedge axis_clk);
        while (!(awready && wready) && n < wait_limit) begin
            @(negedge axis_clk);
            n++;
        end
        if (!(awready && wready)) begin
            timeouts++;
            $display("write to address %h was never accepted", addr);
        end
        @(posedge axis_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic lite_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
        int n;
        n = 0;
        @(posedge axis_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        @(negedge axis_clk);
        while (!arready && n < wait_limit) begin
            @(negedge axis_clk);
            n++;
        end
        if (!arready) begin
            timeouts++;
            $display("read address %h was never accepted", addr);
        end
        @(posedge axis_clk);
        arvalid <= 1'b0;
        n = 0;
        @(negedge axis_clk);
        while (!rvalid && n < wait_limit) begin
            @(negedge axis_clk);
            n++;
        end
        if (!rvalid) begin
            timeouts++;
            $display("no read data came back for address %h", addr);
        end
        // response waits one cycle before rready takes it
        @(posedge axis_clk);
        rready <= 1'b1;
        @(negedge axis_clk);
        data = rdata;
        @(posedge axis_clk);
        rready <= 1'b0;
    endtask

    task automatic load_taps();
        logic [data_w-1:0] rd;
        for (int k = 0; k < tap_num; k++) begin
            taps_model[k] = rand_bits(32);
            lite_write(addr_tap_base + addr_w'(4 * k), taps_model[k]);
        end
        for (int k = 0; k < tap_num; k++) begin
            lite_read(addr_tap_base + addr_w'(4 * k), rd);
            check_value($sformatf("tap[%0d]", k), taps_model[k], rd);
        end
    endtask

    task automatic start_run();
        x_model.delete();
        out_count = 0;
        lite_write(addr_ctrl, 32'd1 << bit_start);
    endtask

    task automatic feed_samples(input int count);
        logic [data_w-1:0] x;
        logic              last;
        int                n;
        for (int i = 0; i < count; i++) begin
            x    = rand_bits(32);
            last = (i == count - 1);
            x_model.push_back(x);
            exp_q.push_back({last, fir_ref(i)});
            @(posedge axis_clk);
            ss_tvalid <= 1'b1;
            ss_tdata  <= x;
            ss_tlast  <= last;
            n = 0;
            @(negedge axis_clk);
            while (!ss_tready && n < wait_limit) begin
                @(negedge axis_clk);
                n++;
            end
            if (!ss_tready) begin
                timeouts++;
                $display("sample %0d was never accepted on the input stream", i);
            end
        end
        @(posedge axis_clk);
        ss_tvalid <= 1'b0;
        ss_tlast  <= 1'b0;
    endtask

    // drain the expected queue, then status shows done once
    task automatic finish_run(input int count);
        logic [data_w-1:0] rd;
        int                n;
        n = 0;
        while (exp_q.size() != 0 && n < run_limit) begin
            @(negedge axis_clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("%0d expected outputs never appeared on the output stream", exp_q.size());
        end
        check_value("output count", count, out_count);
        lite_read(addr_ctrl, rd);
        check_value("ap_ctrl", (32'd1 << bit_done) | (32'd1 << bit_idle), rd);
        lite_read(addr_ctrl, rd);
        check_value("ap_ctrl", 32'd1 << bit_idle, rd);
    endtask

    always @(posedge axis_clk) begin
        lfsr_rdy = lfsr_step(lfsr_rdy);
        sm_tready <= rdy_random ? lfsr_rdy[0] : 1'b1;
    end

    // output stream monitor, sampled mid-cycle
    always @(negedge axis_clk) begin : out_monitor
        logic [data_w:0] exp_word;
        if (axis_rst_n) begin
            if (ss_tvalid && ss_tready) begin
                in_stamp.push_back(cyc);
            end
            if (sm_tvalid && !tvalid_d) begin
                if (in_stamp.size() == 0) begin
                    errors++;
                    $display("sm_tvalid rose with no sample accepted before it");
                end else begin
                    check_value("sm_tvalid latency", latency, cyc - in_stamp.pop_front());
                end
            end
            if (sm_tvalid && sm_tready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("output stream sent a result that was not expected");
                end else begin
                    exp_word = exp_q.pop_front();
                    check_value("sm_tdata", exp_word[data_w-1:0], sm_tdata);
                    check_value("sm_tlast", 32'(exp_word[data_w]), 32'(sm_tlast));
                end
                out_count++;
            end
            tvalid_d = sm_tvalid;
        end
    end

    initial begin : main_seq
        logic [data_w-1:0] rd;
        axis_clk   = 1'b0;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        cyc        = 0;
        lfsr_main  = 32'h9750;
        lfsr_rdy   = 32'h9750;
        rdy_random = 1'b0;
        tvalid_d   = 1'b0;
        errors     = 0;
        timeouts   = 0;
        out_count  = 0;
        repeat (5) @(posedge axis_clk);
        axis_rst_n <= 1'b1;

        lite_read(addr_ctrl, rd);
        check_value("ap_ctrl", 32'd1 << bit_idle, rd);
        load_taps();

        // first run with steady sm_tready
        start_run();
        lite_read(addr_ctrl, rd);
        check_value("ap_idle", 32'd0, 32'(rd[bit_idle]));
        lite_write(addr_tap_base + 12'h00c, ~taps_model[3]);
        lite_read(addr_tap_base + 12'h00c, rd);
        check_value("tap[3]", taps_model[3], rd);
        feed_samples(n_samples);
        finish_run(n_samples);

        // second run, new taps and random back-pressure
        load_taps();
        @(posedge axis_clk);
        rdy_random <= 1'b1;
        start_run();
        feed_samples(n_samples);
        finish_run(n_samples);

        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
fir_regmap_pkg.sv
fir_ctrl_pkg.sv
fir_sample_ring.sv
fir_reg_decode.sv
fir_mac_execute.sv
fir_result_out.sv
fir_top.sv
fir_checker.sv
fir_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the FIR testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fir_tb \
    -f build.f -o fir_sim || { echo "verilator build failed"; exit 1; }

./obj_dir/fir_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
